// File: common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

`define CORE_DATA_WIDTH 32

// commit ring, depth is 2 ** tag width
`define CORE_TAG_WIDTH 3
`define CORE_RING_DEPTH 8

// cycles from acceptance to result bus
`define CORE_ALU_LATENCY 1
`define CORE_MUL_LATENCY 3

`endif

// File: common/core_pkg.sv
`include "core_config.svh"

package core_pkg;

	////////////////////////////////////////
	// words and tags
	////////////////////////////////////////

	// operand or result word
	typedef logic [`CORE_DATA_WIDTH-1:0] data_t;

	// commit ring slot index
	typedef logic [`CORE_TAG_WIDTH-1:0] tag_t;

	////////////////////////////////////////
	// operations
	////////////////////////////////////////

	// mov passes operand a through
	typedef enum logic [1:0] {
		OP_ADD = 2'b00,
		OP_SUB = 2'b01,
		OP_MOV = 2'b10,
		OP_MUL = 2'b11
	} op_t;

endpackage

// File: common/bus_pkg.sv
package bus_pkg;

	////////////////////////////////////////
	// result bus ownership
	////////////////////////////////////////

	// unit driving the bus in a given cycle
	typedef enum logic {
		SRC_ALU = 1'b0,
		SRC_MUL = 1'b1
	} source_t;

	// one stage of the reservation shift register
	typedef struct packed {
		logic valid;
		source_t source;
	} slot_t;

endpackage

// File: source/dispatch.sv
module dispatch (
	input logic issue_valid,
	input core_pkg::op_t issue_op,
	input core_pkg::data_t issue_a,
	input core_pkg::data_t issue_b,
	output logic issue_ready,
	input logic ring_full,
	input logic alu_grant,
	output logic alloc,
	output logic alu_start,
	output logic mul_start
);
	import core_pkg::*;

	logic is_mul;
	logic transfer;

	////////////////////////////////////////
	// acceptance
	////////////////////////////////////////

	assign is_mul = issue_op == OP_MUL;

	// a multiply reserves its own slot, alu ops need a free one
	assign issue_ready = !ring_full && (is_mul || alu_grant);

	assign transfer = issue_valid && issue_ready;

	////////////////////////////////////////
	// routing
	////////////////////////////////////////

	// tail slot of the ring is taken on every transfer
	assign alloc = transfer;

	assign alu_start = transfer && !is_mul;
	assign mul_start = transfer && is_mul;
endmodule

// File: source/alu_unit.sv
module alu_unit (
	input logic clk,
	input logic reset,
	input logic start,
	input core_pkg::op_t op,
	input core_pkg::data_t a,
	input core_pkg::data_t b,
	input core_pkg::tag_t tag,
	output logic result_valid,
	output core_pkg::tag_t result_tag,
	output core_pkg::data_t result
);
	import core_pkg::*;

	data_t value;

	// add, sub, mov; mul never arrives here
	always_comb begin
		case (op)
			OP_ADD: value = a + b;
			OP_SUB: value = a - b;
			default: value = a;
		endcase
	end

	// valid bit
	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= start;
		end
	end

	// result and tag
	always_ff @(posedge clk) begin
		if (start) begin
			result <= value;
			result_tag <= tag;
		end
	end
endmodule

// File: source/mul_unit.sv
`include "core_config.svh"

module mul_unit (
	input logic clk,
	input logic start,
	input core_pkg::data_t a,
	input core_pkg::data_t b,
	input core_pkg::tag_t tag,
	output core_pkg::tag_t result_tag,
	output core_pkg::data_t result
);
	import core_pkg::*;

	localparam int LAST = `CORE_MUL_LATENCY - 1;

	data_t a_q;
	data_t b_q;
	data_t product_q;
	data_t result_q;
	tag_t tag_pipe [`CORE_MUL_LATENCY];

	////////////////////////////////////////
	// data pipeline
	////////////////////////////////////////

	// operand capture
	always_ff @(posedge clk) begin
		if (start) begin
			a_q <= a;
			b_q <= b;
		end
	end

	// low half of the product only
	always_ff @(posedge clk) begin
		product_q <= a_q * b_q;
		result_q <= product_q;
	end

	////////////////////////////////////////
	// tag pipeline
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start) begin
			tag_pipe[0] <= tag;
		end
		for (int i = 1; i < `CORE_MUL_LATENCY; i++) begin
			tag_pipe[i] <= tag_pipe[i-1];
		end
	end

	assign result = result_q;
	assign result_tag = tag_pipe[LAST];
endmodule

// File: result_bus/result_bus_arbiter.sv
`include "core_config.svh"

module result_bus_arbiter (
	input logic clk,
	input logic reset,
	input logic mul_start,
	input logic alu_valid,
	input core_pkg::tag_t alu_tag,
	input core_pkg::data_t alu_result,
	input core_pkg::tag_t mul_tag,
	input core_pkg::data_t mul_result,
	output logic alu_grant,
	output logic bus_valid,
	output core_pkg::tag_t bus_tag,
	output core_pkg::data_t bus_data
);
	import core_pkg::*;
	import bus_pkg::*;

	localparam int LAST = `CORE_MUL_LATENCY - 1;
	// stage that reaches the bus when a granted alu result does
	localparam int ALU_CHECK = LAST - `CORE_ALU_LATENCY;

	slot_t stage [`CORE_MUL_LATENCY];
	slot_t cur_slot;

	////////////////////////////////////////
	// reservations
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_MUL_LATENCY; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0].valid <= mul_start;
			stage[0].source <= SRC_MUL;
			for (int i = 1; i < `CORE_MUL_LATENCY; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign alu_grant = !stage[ALU_CHECK].valid;

	////////////////////////////////////////
	// bus mux
	////////////////////////////////////////

	// reserved slot first, otherwise whatever the alu holds
	always_comb begin
		if (stage[LAST].valid) begin
			cur_slot = stage[LAST];
		end else begin
			cur_slot.valid = alu_valid;
			cur_slot.source = SRC_ALU;
		end
	end

	assign bus_valid = cur_slot.valid;
	assign bus_tag = cur_slot.source == SRC_MUL ? mul_tag : alu_tag;
	assign bus_data = cur_slot.source == SRC_MUL ? mul_result : alu_result;

	// the grant one cycle earlier must have kept these apart
	a_no_collision: assert property (
		@(posedge clk) disable iff (reset)
		alu_valid |-> !stage[LAST].valid
	) else $error("alu result collides with a multiply on the bus");
endmodule

// File: commit_ring/commit_ring.sv
`include "core_config.svh"

module commit_ring (
	input logic clk,
	input logic reset,
	input logic alloc,
	output core_pkg::tag_t alloc_tag,
	output logic ring_full,
	input logic bus_valid,
	input core_pkg::tag_t bus_tag,
	input core_pkg::data_t bus_data,
	output logic commit_valid,
	output core_pkg::tag_t commit_tag,
	output core_pkg::data_t commit_data,
	input logic commit_ready
);
	import core_pkg::*;

	data_t entry_data [`CORE_RING_DEPTH];
	logic [`CORE_RING_DEPTH-1:0] done;
	tag_t head;
	tag_t tail;
	logic [`CORE_TAG_WIDTH:0] count;
	logic release_head;

	////////////////////////////////////////
	// allocation side
	////////////////////////////////////////

	assign alloc_tag = tail;
	assign ring_full = count == `CORE_RING_DEPTH;

	////////////////////////////////////////
	// commit side
	////////////////////////////////////////

	// done is only ever set on allocated entries
	assign commit_valid = done[head];
	assign commit_tag = head;
	assign commit_data = entry_data[head];
	assign release_head = commit_valid && commit_ready;

	////////////////////////////////////////
	// pointers and flags
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
		end else begin
			if (alloc) begin
				tail <= tail + 1'b1;
			end
			if (release_head) begin
				head <= head + 1'b1;
			end
			case ({alloc, release_head})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// bus writes an undone entry, release clears a done one
			if (bus_valid) begin
				done[bus_tag] <= 1'b1;
			end
			if (release_head) begin
				done[head] <= 1'b0;
			end
		end
	end

	// result storage
	always_ff @(posedge clk) begin
		if (bus_valid) begin
			entry_data[bus_tag] <= bus_data;
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_no_alloc_full: assert property (
		@(posedge clk) disable iff (reset)
		alloc |-> !ring_full
	) else $error("allocation into a full ring");

	// every result belongs to a live, unfinished entry
	a_bus_write_live: assert property (
		@(posedge clk) disable iff (reset)
		bus_valid |-> (tag_t'(bus_tag - head) < count) && !done[bus_tag]
	) else $error("bus write to a free or finished entry");
endmodule

// File: source/exec_core.sv
module exec_core (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input core_pkg::op_t issue_op,
	input core_pkg::data_t issue_a,
	input core_pkg::data_t issue_b,
	output logic issue_ready,
	output logic commit_valid,
	output core_pkg::tag_t commit_tag,
	output core_pkg::data_t commit_data,
	input logic commit_ready
);
	import core_pkg::*;

	// ring allocation
	logic alloc;
	tag_t alloc_tag;
	logic ring_full;

	// unit starts and bus grant
	logic alu_start;
	logic mul_start;
	logic alu_grant;

	// unit results
	logic alu_valid;
	tag_t alu_tag;
	data_t alu_result;
	tag_t mul_tag;
	data_t mul_result;

	// shared result bus
	logic bus_valid;
	tag_t bus_tag;
	data_t bus_data;

	dispatch i_dispatch (
		.issue_valid,
		.issue_op,
		.issue_a,
		.issue_b,
		.issue_ready,
		.ring_full,
		.alu_grant,
		.alloc,
		.alu_start,
		.mul_start
	);

	alu_unit i_alu_unit (
		.clk,
		.reset,
		.start(alu_start),
		.op(issue_op),
		.a(issue_a),
		.b(issue_b),
		.tag(alloc_tag),
		.result_valid(alu_valid),
		.result_tag(alu_tag),
		.result(alu_result)
	);

	mul_unit i_mul_unit (
		.clk,
		.start(mul_start),
		.a(issue_a),
		.b(issue_b),
		.tag(alloc_tag),
		.result_tag(mul_tag),
		.result(mul_result)
	);

	result_bus_arbiter i_result_bus_arbiter (
		.clk,
		.reset,
		.mul_start,
		.alu_valid,
		.alu_tag,
		.alu_result,
		.mul_tag,
		.mul_result,
		.alu_grant,
		.bus_valid,
		.bus_tag,
		.bus_data
	);

	commit_ring i_commit_ring (
		.clk,
		.reset,
		.alloc,
		.alloc_tag,
		.ring_full,
		.bus_valid,
		.bus_tag,
		.bus_data,
		.commit_valid,
		.commit_tag,
		.commit_data,
		.commit_ready
	);
endmodule

// File: tests/program_table.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// columns: name, operation, operand a, operand b, expected result
// rows after mark_pressure_block() are issued with commit held off

task automatic load_program();
	// alu only
	add_row("add_small", OP_ADD, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c);
	add_row("add_wrap", OP_ADD, 32'hffff_ffff, 32'h0000_0002, 32'h0000_0001);
	add_row("sub_small", OP_SUB, 32'h0000_0064, 32'h0000_0020, 32'h0000_0044);
	add_row("sub_wrap", OP_SUB, 32'h0000_0003, 32'h0000_0005, 32'hffff_fffe);
	add_row("mov_value", OP_MOV, 32'hdead_beef, 32'h1234_5678, 32'hdead_beef);

	// multiplies with alu ops close behind
	add_row("mul_small", OP_MUL, 32'h0000_0006, 32'h0000_0007, 32'h0000_002a);
	add_row("add_after_mul", OP_ADD, 32'h0000_1000, 32'h0000_0234, 32'h0000_1234);
	add_row("mov_after_mul", OP_MOV, 32'hcafe_f00d, 32'h0000_0000, 32'hcafe_f00d);
	add_row("mul_wrap", OP_MUL, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000);
	add_row("mul_high", OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
	add_row("sub_after_mul", OP_SUB, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff);
	add_row("mul_mixed", OP_MUL, 32'h1234_5678, 32'h0000_0010, 32'h2345_6780);
	add_row("mul_back", OP_MUL, 32'h0000_0100, 32'h0000_0003, 32'h0000_0300);
	add_row("add_zero", OP_ADD, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000);
	add_row("mul_neg", OP_MUL, 32'hffff_fffe, 32'h0000_0003, 32'hffff_fffa);
	add_row("add_carry", OP_ADD, 32'h0000_ffff, 32'h0000_0001, 32'h0001_0000);
	add_row("mov_last", OP_MOV, 32'h0bad_c0de, 32'hffff_ffff, 32'h0bad_c0de);

	// one full ring under back-pressure
	mark_pressure_block();
	add_row("bp_mul_0", OP_MUL, 32'h0000_0009, 32'h0000_0009, 32'h0000_0051);
	add_row("bp_add_1", OP_ADD, 32'h0000_0100, 32'h0000_0001, 32'h0000_0101);
	add_row("bp_mul_2", OP_MUL, 32'h0000_1000, 32'h0000_1000, 32'h0100_0000);
	add_row("bp_sub_3", OP_SUB, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff);
	add_row("bp_mov_4", OP_MOV, 32'h55aa_55aa, 32'h0000_0000, 32'h55aa_55aa);
	add_row("bp_mul_5", OP_MUL, 32'h0000_000b, 32'h0000_000d, 32'h0000_008f);
	add_row("bp_add_6", OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
	add_row("bp_mul_7", OP_MUL, 32'h0000_0007, 32'h0000_0008, 32'h0000_0038);

	// issue resumes once the ring drains
	add_row("after_add", OP_ADD, 32'h0000_0011, 32'h0000_0022, 32'h0000_0033);
	add_row("after_mul", OP_MUL, 32'h0000_0005, 32'h0000_0005, 32'h0000_0019);
endtask

`endif

// File: tests/exec_core_tb.sv
`include "core_config.svh"

module exec_core_tb;
	import core_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY = 1;
	localparam int TIMEOUT = 200;
	localparam int FULL_CHECK_CYCLES = 6;

	logic clk;
	logic reset;
	logic issue_valid;
	op_t issue_op;
	data_t issue_a;
	data_t issue_b;
	logic issue_ready;
	logic commit_valid;
	tag_t commit_tag;
	data_t commit_data;
	logic commit_ready;

	// program table
	string row_name [$];
	op_t row_op [$];
	data_t row_a [$];
	data_t row_b [$];
	data_t row_expected [$];
	int pressure_start;

	// random timing drawn once after seeding
	int unsigned issue_gap [$];
	int unsigned commit_stall [$];

	int issue_count;
	int commit_count;
	logic hold_commit;

	exec_core i_dut (
		.clk,
		.reset,
		.issue_valid,
		.issue_op,
		.issue_a,
		.issue_b,
		.issue_ready,
		.commit_valid,
		.commit_tag,
		.commit_data,
		.commit_ready
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic add_row(input string name, input op_t op, input data_t a, input data_t b,
			input data_t expected);
		row_name.push_back(name);
		row_op.push_back(op);
		row_a.push_back(a);
		row_b.push_back(b);
		row_expected.push_back(expected);
	endtask

	task automatic mark_pressure_block();
		pressure_start = row_op.size();
	endtask

	`include "program_table.svh"

	////////////////////////////////////////
	// checking
	////////////////////////////////////////

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("FAILED %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	////////////////////////////////////////
	// issue side
	////////////////////////////////////////

	// holds the request until issue_ready is seen at an edge
	task automatic issue_row(input int i);
		int waited;
		waited = 0;
		issue_valid = 1'b1;
		issue_op = row_op[i];
		issue_a = row_a[i];
		issue_b = row_b[i];
		@(posedge clk);
		while (!issue_ready) begin
			waited++;
			if (waited > TIMEOUT) begin
				stop_with_failure($sformatf("timeout waiting for issue_ready on %s",
					row_name[i]));
			end
			@(posedge clk);
		end
		#DRIVE_DELAY;
		issue_valid = 1'b0;
		issue_count++;
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (commit_count != issue_count) begin
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
			if (waited > TIMEOUT) begin
				stop_with_failure("timeout waiting for the ring to drain");
			end
		end
	endtask

	// ring full with nothing committed and the head result landed
	task automatic check_full_stall();
		repeat (FULL_CHECK_CYCLES) begin
			@(posedge clk);
			compare("issue_ready with full ring", 32'd0, 32'(issue_ready));
		end
		compare("head done under back-pressure", 32'd1, 32'(commit_valid));
		#DRIVE_DELAY;
		compare("commits held under back-pressure", 32'(pressure_start), 32'(commit_count));
		hold_commit = 1'b0;
	endtask

	task automatic drive_program();
		for (int i = 0; i < row_op.size(); i++) begin
			if (i == pressure_start) begin
				wait_for_drain();
				hold_commit = 1'b1;
			end
			repeat (issue_gap[i]) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
			issue_row(i);
			if (pressure_start >= 0 && i == pressure_start + `CORE_RING_DEPTH - 1) begin
				check_full_stall();
			end
		end
	endtask

	////////////////////////////////////////
	// commit side
	////////////////////////////////////////

	task automatic watch_commits();
		int stall_left;
		int idle;
		logic next_ready;
		stall_left = 0;
		idle = 0;
		while (commit_count < row_op.size()) begin
			@(posedge clk);
			if (commit_valid && commit_count >= issue_count) begin
				stop_with_failure("commit_valid high with no instruction outstanding");
			end
			if (commit_valid && commit_ready) begin
				compare({row_name[commit_count], " tag"},
					32'(commit_count % `CORE_RING_DEPTH), 32'(commit_tag));
				compare({row_name[commit_count], " data"},
					row_expected[commit_count], commit_data);
				stall_left = commit_stall[commit_count];
				commit_count++;
				idle = 0;
			end else if (commit_count < issue_count) begin
				idle++;
				if (idle > TIMEOUT) begin
					stop_with_failure("timeout waiting for commit_valid");
				end
			end else begin
				idle = 0;
			end
			if (stall_left > 0) begin
				next_ready = 1'b0;
				stall_left--;
			end else begin
				next_ready = !hold_commit;
			end
			#DRIVE_DELAY;
			commit_ready = next_ready;
		end
	endtask

	////////////////////////////////////////
	// main
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = OP_ADD;
		issue_a = '0;
		issue_b = '0;
		commit_ready = 1'b0;
		hold_commit = 1'b0;
		issue_count = 0;
		commit_count = 0;
		pressure_start = -1;

		void'($urandom(32'h8d47));
		load_program();
		foreach (row_op[i]) begin
			issue_gap.push_back(($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 3));
			commit_stall.push_back(($urandom_range(0, 3) == 0) ? $urandom_range(1, 4) : 0);
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		fork
			drive_program();
			watch_commits();
		join

		// nothing left over once every row has committed
		commit_ready = 1'b1;
		repeat (4) begin
			@(posedge clk);
			compare("no extra commit", 32'd0, 32'(commit_valid));
		end

		$display("Testbench passed");
		$finish;
	end
endmodule

// File: list.f
+incdir+common
+incdir+tests
common/core_pkg.sv
common/bus_pkg.sv
source/dispatch.sv
source/alu_unit.sv
source/mul_unit.sv
result_bus/result_bus_arbiter.sv
commit_ring/commit_ring.sv
source/exec_core.sv
tests/exec_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= exec_core_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR VFLAGS TOP FILE_LIST BUILD_DIR PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)" || { echo "pass message not found"; exit 1; }

clean:
	rm -rf $(BUILD_DIR)
